/* files.f */
src/isp_pkg.sv
src/frame_counter.sv
src/isp_cfg_apb.sv
src/route_select.sv
src/isp_blc.sv
src/isp_wb.sv
src/isp_gamma.sv
src/isp_mux_top.sv
tests/isp_mux_asserts.sv
tests/tb_isp_mux.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_isp_mux \
		-Mdir obj_dir -f files.f
	./obj_dir/Vtb_isp_mux | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_isp_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_isp_mux;
    import isp_pkg::*;

    localparam int IMG_W = 8;
    localparam int IMG_H = 4;
    localparam int FRAME_PIX = IMG_W * IMG_H;
    // about 300 cycles for five frames, gaps and register traffic
    localparam int TIMEOUT_CYCLES = 3000;

    logic        mux_clk = 1'b0;
    logic        rst_n;
    logic [15:0] sd_data;
    logic        sd_data_en;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    rgb_beat_t   out0;
    rgb_beat_t   out1;

    // register words, pending mirror and the set the pixels see
    logic [31:0] m_pend_route;
    logic [31:0] m_pend_black;
    logic [31:0] m_pend_gain;
    logic [31:0] m_act_route;
    logic [31:0] m_act_black;
    logic [31:0] m_act_gain;
    logic [23:0] exp0_q[$];
    logic [23:0] exp1_q[$];
    int          col = 0;
    int          row = 0;
    int          cycle_cnt = 0;
    logic [31:0] rd_word;
    logic        rd_err;

    isp_mux_top #(.IMG_WIDTH(IMG_W), .IMG_HEIGHT(IMG_H)) u_isp_mux_top (
        .mux_clk(mux_clk), .rst_n(rst_n), .sd_data(sd_data), .sd_data_en(sd_data_en),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .out0(out0), .out1(out1)
    );

    always #4 mux_clk = ~mux_clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    always @(posedge mux_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    function automatic logic [7:0] scale_channel(input logic [7:0] ch, input logic [7:0] gain);
        int v;
        v = (int'(ch) * int'(gain)) / 64;
        if (v > 255) begin
            v = 255;
        end
        return v[7:0];
    endfunction

    function automatic logic [7:0] knee_curve(input logic [7:0] x);
        int v;
        if (x < 8'd64) begin
            v = 2 * int'(x);
        end else begin
            v = 128 + (2 * (int'(x) - 64)) / 3;
        end
        return v[7:0];
    endfunction

    function automatic logic [23:0] gain_rgb(input logic [23:0] p);
        return {scale_channel(p[23:16], m_act_gain[7:0]),
                scale_channel(p[15:8], m_act_gain[15:8]),
                scale_channel(p[7:0], m_act_gain[23:16])};
    endfunction

    function automatic logic [23:0] knee_rgb(input logic [23:0] p);
        return {knee_curve(p[23:16]), knee_curve(p[15:8]), knee_curve(p[7:0])};
    endfunction

    function automatic logic [23:0] pick_tap(input logic [3:0] sel, input logic [23:0] demo,
                                             input logic [23:0] wbv, input logic [23:0] gmv);
        if (sel == WB) begin
            return wbv;
        end
        if (sel == GAMMA) begin
            return gmv;
        end
        return demo;
    endfunction

    // model of one pixel under the active register words
    task automatic expect_pixel(input logic [7:0] x, input logic [1:0] ph);
        logic [7:0]  lvl;
        logic [7:0]  raw;
        logic [23:0] demo;
        logic [23:0] wbv;
        logic [23:0] gmv;
        lvl = m_act_black[int'(ph) * 8 +: 8];
        raw = x;
        if (m_act_route[3:0] == BLC) begin
            raw = (x > lvl) ? x - lvl : 8'd0;
        end
        demo = {raw, raw, raw};
        if (m_act_route[7:4] == GAMMA) begin
            gmv = knee_rgb(demo);
            wbv = gain_rgb(gmv);
        end else begin
            wbv = gain_rgb(demo);
            gmv = (m_act_route[11:8] == WB) ? knee_rgb(wbv) : knee_rgb(demo);
        end
        exp0_q.push_back(pick_tap(m_act_route[15:12], demo, wbv, gmv));
        exp1_q.push_back(pick_tap(m_act_route[19:16], demo, wbv, gmv));
    endtask

    task automatic check_beat(input int port, input logic [23:0] got);
        logic [23:0] exp;
        int          depth;
        depth = (port == 0) ? exp0_q.size() : exp1_q.size();
        assert (depth != 0) begin
            exp = (port == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
            assert (got == exp) else stop_on_error($sformatf(
                "mismatch out%0d.pix: got 0x%h expected 0x%h", port, got, exp));
        end else begin
            stop_on_error($sformatf("out%0d gave a valid beat with no pixel pending", port));
        end
    endtask

    always @(posedge mux_clk) begin
        if (rst_n && out0.en) begin
            check_beat(0, out0.pix);
        end
        if (rst_n && out1.en) begin
            check_beat(1, out1.pix);
        end
    end

    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(posedge mux_clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge mux_clk);
        penable <= 1'b1;
        @(posedge mux_clk);
        while (!pready) begin
            @(posedge mux_clk);
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        assert (!err) else stop_on_error($sformatf("write to 0x%h raised pslverr", addr));
        case (addr)
            ADDR_ROUTE: m_pend_route = {12'd0, data[19:0]};
            ADDR_BLACK: m_pend_black = data;
            default:    m_pend_gain = {8'd0, data[23:0]};
        endcase
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'd0, rdata, err);
        assert (!err) else stop_on_error($sformatf("read of 0x%h raised pslverr", addr));
        assert (rdata == exp) else stop_on_error($sformatf(
            "mismatch prdata at 0x%h: got 0x%h expected 0x%h", addr, rdata, exp));
    endtask

    task automatic send_pixels(input int count);
        logic [31:0] rnd;
        logic [7:0]  x;
        int          i;
        for (i = 0; i < count; i++) begin
            @(posedge mux_clk);
            rnd = $urandom;
            x = rnd[15:8];
            // push some pixels to the ends of the range
            if (i % 8 == 3) begin
                x = {4'h0, rnd[19:16]};
            end
            if (i % 8 == 6) begin
                x = {4'hf, rnd[19:16]};
            end
            sd_data    <= {x, rnd[7:0]};
            sd_data_en <= 1'b1;
            expect_pixel(x, {row[0], col[0]});
            col = col + 1;
            if (col == IMG_W) begin
                col = 0;
                row = (row + 1) % IMG_H;
            end
        end
        @(posedge mux_clk);
        sd_data_en <= 1'b0;
    endtask

    // twelve idle cycles, the commit lands inside the gap
    task automatic idle_gap();
        repeat (11) @(posedge mux_clk);
        m_act_route = m_pend_route;
        m_act_black = m_pend_black;
        m_act_gain  = m_pend_gain;
    endtask

    initial begin
        void'($urandom(21373));
        rst_n      <= 1'b0;
        sd_data    <= '0;
        sd_data_en <= 1'b0;
        paddr      <= '0;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        pwdata     <= '0;
        // reset route is src, demosaic, wb, gamma, demosaic with unity gains
        m_pend_route = 32'h0003_6430;
        m_pend_black = 32'h0000_0000;
        m_pend_gain  = 32'h0040_4040;
        m_act_route  = m_pend_route;
        m_act_black  = m_pend_black;
        m_act_gain   = m_pend_gain;
        repeat (8) @(posedge mux_clk);
        rst_n <= 1'b1;

        check_reg(ADDR_ROUTE, m_pend_route);
        check_reg(ADDR_BLACK, m_pend_black);
        check_reg(ADDR_GAIN, m_pend_gain);

        // frame A runs on reset values while blc waits in pending
        write_reg(ADDR_BLACK, 32'h3020_1008);
        write_reg(ADDR_ROUTE, 32'h0003_6432);
        send_pixels(FRAME_PIX);
        idle_gap();

        // frame B shows blc gray on out1
        write_reg(ADDR_GAIN, 32'h0080_3060);
        write_reg(ADDR_ROUTE, 32'h0004_6432);
        send_pixels(FRAME_PIX);
        idle_gap();

        // frame C has wb before gamma, wb tap on out1
        write_reg(ADDR_ROUTE, 32'h0006_4362);
        send_pixels(FRAME_PIX);
        idle_gap();

        // frame D has gamma before wb, new values arrive mid frame
        send_pixels(13);
        write_reg(ADDR_ROUTE, 32'h0003_6430);
        write_reg(ADDR_GAIN, 32'h0020_904c);
        apb_transfer(1'b1, 8'h0c, 32'hdead_beef, rd_word, rd_err);
        assert (rd_err) else stop_on_error("write to unknown address 0x0c gave no pslverr");
        check_reg(ADDR_ROUTE, m_pend_route);
        check_reg(ADDR_BLACK, m_pend_black);
        check_reg(ADDR_GAIN, m_pend_gain);
        send_pixels(FRAME_PIX - 13);
        idle_gap();

        // frame E picks up the mid frame writes
        send_pixels(FRAME_PIX);
        while (exp0_q.size() != 0 || exp1_q.size() != 0) begin
            @(posedge mux_clk);
        end
        // a few more edges so a stray extra beat is still caught
        repeat (10) @(posedge mux_clk);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/isp_mux_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_mux_asserts (
    input logic mux_clk,
    input logic rst_n,
    input logic sd_data_en,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic frame_end,
    input logic out0_en,
    input logic out1_en
);

    // input enables of the last seven edges, newest in bit 0
    logic [6:0] en_hist;

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_hist <= '0;
        end else begin
            en_hist <= {en_hist[5:0], sd_data_en};
        end
    end

    a_pready_high: assert property (@(posedge mux_clk) disable iff (!rst_n) pready)
        else $error("pready dropped low");

    a_slverr_access: assert property (@(posedge mux_clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an access phase");

    // longest route is blc plus both stages plus the tap
    a_out_latency: assert property (@(posedge mux_clk) disable iff (!rst_n)
        (out0_en || out1_en) |-> (en_hist != '0))
        else $error("output enable without an input enable in the last 7 cycles");

    a_reset_quiet: assert property (@(posedge mux_clk)
        !rst_n |-> (!out0_en && !out1_en && !pslverr && !frame_end))
        else $error("output enable, pslverr or frame_end high during reset");

endmodule

bind isp_mux_top isp_mux_asserts u_isp_mux_asserts (
    .mux_clk(mux_clk),
    .rst_n(rst_n),
    .sd_data_en(sd_data_en),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .frame_end(frame_end),
    .out0_en(out0.en),
    .out1_en(out1.en)
);

`default_nettype wire

/* src/isp_mux_top.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_mux_top #(
    parameter int IMG_WIDTH  = 1936,
    parameter int IMG_HEIGHT = 1088
) (
    input  logic               mux_clk,
    input  logic               rst_n,
    input  logic [15:0]        sd_data,
    input  logic               sd_data_en,
    input  logic [7:0]         paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output isp_pkg::rgb_beat_t out0,
    output isp_pkg::rgb_beat_t out1
);
    import isp_pkg::*;

    isp_cfg_t     cfg;
    bayer_phase_t phase;
    logic         frame_end;
    raw_beat_t    src_beat;
    raw_beat_t    blc_beat;
    raw_beat_t    raw_beat;
    rgb_beat_t    demo_beat;
    rgb_beat_t    wb_in;
    rgb_beat_t    wb_beat;
    rgb_beat_t    gamma_in;
    rgb_beat_t    gamma_beat;

    // raw sample is the top byte of the 12-bit field
    assign src_beat  = '{en: sd_data_en, pix: sd_data[15:8]};
    // gray demosaic, every channel carries the raw value
    assign demo_beat = '{en: raw_beat.en, pix: '{r: raw_beat.pix, g: raw_beat.pix, b: raw_beat.pix}};

    frame_counter #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_frame_counter (
        .mux_clk(mux_clk), .rst_n(rst_n), .pix_en(sd_data_en),
        .phase(phase), .frame_end(frame_end)
    );

    isp_cfg_apb #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_isp_cfg_apb (
        .mux_clk(mux_clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .pix_en(sd_data_en), .frame_end(frame_end), .cfg(cfg)
    );

    isp_blc u_isp_blc (
        .mux_clk(mux_clk), .rst_n(rst_n), .in_beat(src_beat), .phase(phase),
        .black(cfg.black), .out_beat(blc_beat)
    );

    // unused third candidate repeats the fallback
    route_select #(.beat_t(raw_beat_t)) u_raw_sel (
        .mux_clk(mux_clk), .rst_n(rst_n), .sel(cfg.raw_sel), .cand_a(src_beat),
        .cand_b(blc_beat), .cand_c(src_beat), .cand_ids('{SRC, BLC, SRC}), .y(raw_beat)
    );

    route_select #(.beat_t(rgb_beat_t)) u_wb_sel (
        .mux_clk(mux_clk), .rst_n(rst_n), .sel(cfg.wb_sel), .cand_a(demo_beat),
        .cand_b(gamma_beat), .cand_c(demo_beat), .cand_ids('{DEMOSAIC, GAMMA, DEMOSAIC}),
        .y(wb_in)
    );

    isp_wb u_isp_wb (
        .mux_clk(mux_clk), .rst_n(rst_n), .in_beat(wb_in), .gain_r(cfg.wb_gain_r),
        .gain_g(cfg.wb_gain_g), .gain_b(cfg.wb_gain_b), .out_beat(wb_beat)
    );

    route_select #(.beat_t(rgb_beat_t)) u_gamma_sel (
        .mux_clk(mux_clk), .rst_n(rst_n), .sel(cfg.gamma_sel), .cand_a(demo_beat),
        .cand_b(wb_beat), .cand_c(demo_beat), .cand_ids('{DEMOSAIC, WB, DEMOSAIC}),
        .y(gamma_in)
    );

    isp_gamma u_isp_gamma (
        .mux_clk(mux_clk), .rst_n(rst_n), .in_beat(gamma_in), .out_beat(gamma_beat)
    );

    // output taps, any unlisted id shows the demosaic beat
    route_select #(.beat_t(rgb_beat_t)) u_out0_sel (
        .mux_clk(mux_clk), .rst_n(rst_n), .sel(cfg.out0_sel), .cand_a(demo_beat),
        .cand_b(wb_beat), .cand_c(gamma_beat), .cand_ids('{DEMOSAIC, WB, GAMMA}), .y(out0)
    );

    route_select #(.beat_t(rgb_beat_t)) u_out1_sel (
        .mux_clk(mux_clk), .rst_n(rst_n), .sel(cfg.out1_sel), .cand_a(demo_beat),
        .cand_b(wb_beat), .cand_c(gamma_beat), .cand_ids('{DEMOSAIC, WB, GAMMA}), .y(out1)
    );

endmodule

`default_nettype wire

/* src/isp_gamma.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_gamma (
    input  logic               mux_clk,
    input  logic               rst_n,
    input  isp_pkg::rgb_beat_t in_beat,
    output isp_pkg::rgb_beat_t out_beat
);
    import isp_pkg::*;

    pix_rgb_t curved;
    pix_rgb_t pix_q;
    logic     en_q;

    // slope 2 in the shadows, 2/3 above the knee at 64
    function automatic logic [7:0] knee(input logic [7:0] x);
        logic [7:0] above;
        logic [8:0] twice;
        above = x - 8'd64;
        twice = {above, 1'b0};
        if (x < 8'd64) begin
            return {x[6:0], 1'b0};
        end
        return 8'd128 + 8'(twice / 9'd3);
    endfunction

    always_comb begin
        curved.r = knee(in_beat.pix.r);
        curved.g = knee(in_beat.pix.g);
        curved.b = knee(in_beat.pix.b);
    end

    always_ff @(posedge mux_clk) begin
        if (in_beat.en) begin
            pix_q <= curved;
        end
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= in_beat.en;
        end
    end

    assign out_beat = '{en: en_q, pix: pix_q};

endmodule

`default_nettype wire

/* src/isp_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_wb (
    input  logic               mux_clk,
    input  logic               rst_n,
    input  isp_pkg::rgb_beat_t in_beat,
    input  logic [7:0]         gain_r,
    input  logic [7:0]         gain_g,
    input  logic [7:0]         gain_b,
    output isp_pkg::rgb_beat_t out_beat
);
    import isp_pkg::*;

    pix_rgb_t bal;
    pix_rgb_t pix_q;
    logic     en_q;

    // gain is u2.6, so 64 leaves the channel untouched
    function automatic logic [7:0] apply_gain(
        input logic [7:0] ch,
        input logic [7:0] gain
    );
        logic [15:0] prod;
        logic [9:0]  scaled;
        prod   = ch * gain;
        scaled = prod[15:6];
        if (scaled > 10'd255) begin
            return 8'hff;
        end
        return scaled[7:0];
    endfunction

    always_comb begin
        bal.r = apply_gain(in_beat.pix.r, gain_r);
        bal.g = apply_gain(in_beat.pix.g, gain_g);
        bal.b = apply_gain(in_beat.pix.b, gain_b);
    end

    always_ff @(posedge mux_clk) begin
        if (in_beat.en) begin
            pix_q <= bal;
        end
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= in_beat.en;
        end
    end

    assign out_beat = '{en: en_q, pix: pix_q};

endmodule

`default_nettype wire

/* src/isp_blc.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_blc (
    input  logic                  mux_clk,
    input  logic                  rst_n,
    input  isp_pkg::raw_beat_t    in_beat,
    input  isp_pkg::bayer_phase_t phase,
    input  logic [3:0][7:0]       black,
    output isp_pkg::raw_beat_t    out_beat
);
    import isp_pkg::*;

    pix_raw_t level;
    pix_raw_t corr;
    pix_raw_t pix_q;
    logic     en_q;

    // each colour site of the 2x2 cell has its own pedestal
    assign level = black[phase];

    // anything under the pedestal is noise, clamp to zero
    always_comb begin
        if (in_beat.pix > level) begin
            corr = in_beat.pix - level;
        end else begin
            corr = '0;
        end
    end

    // payload only moves on a valid pixel
    always_ff @(posedge mux_clk) begin
        if (in_beat.en) begin
            pix_q <= corr;
        end
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= in_beat.en;
        end
    end

    assign out_beat = '{en: en_q, pix: pix_q};

endmodule

`default_nettype wire

/* src/route_select.sv */
`timescale 1ns/1ps
`default_nettype none

module route_select #(
    parameter type beat_t = isp_pkg::rgb_beat_t
) (
    input  logic                     mux_clk,
    input  logic                     rst_n,
    input  isp_pkg::stage_id_t       sel,
    input  beat_t                    cand_a,
    input  beat_t                    cand_b,
    input  beat_t                    cand_c,
    input  isp_pkg::stage_id_t [0:2] cand_ids,
    output beat_t                    y
);

    beat_t pick;
    beat_t pay_q;
    logic  en_q;

    // first matching id wins, no match falls back to cand_a
    always_comb begin
        pick = cand_a;
        if (sel == cand_ids[2]) begin
            pick = cand_c;
        end
        if (sel == cand_ids[1]) begin
            pick = cand_b;
        end
        if (sel == cand_ids[0]) begin
            pick = cand_a;
        end
    end

    always_ff @(posedge mux_clk) begin
        pay_q <= pick;
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= pick.en;
        end
    end

    always_comb begin
        y    = pay_q;
        y.en = en_q;
    end

endmodule

`default_nettype wire

/* src/isp_cfg_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_cfg_apb #(
    parameter int IMG_WIDTH  = 1936,
    parameter int IMG_HEIGHT = 1088
) (
    input  logic              mux_clk,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              pix_en,
    input  logic              frame_end,
    output isp_pkg::isp_cfg_t cfg
);
    import isp_pkg::*;

    localparam int CW = $clog2(DRAIN_CYCLES + 1);

    isp_cfg_t      pend;
    logic          armed;
    logic [CW-1:0] idle_cnt;
    logic          access;
    logic          addr_hit;
    logic          commit;

    // bayer phase assumes whole 2x2 cells in every frame
    if ((IMG_WIDTH % 2) != 0 || (IMG_HEIGHT % 2) != 0) begin : g_bad_size
        $error("isp_cfg_apb: image width and height must be even");
    end

    assign access   = psel && penable;
    assign addr_hit = (paddr == ADDR_ROUTE) || (paddr == ADDR_BLACK) || (paddr == ADDR_GAIN);
    assign pready   = 1'b1;
    assign pslverr  = access && !addr_hit;

    // readback shows pending values, not the active set
    always_comb begin
        case (paddr)
            ADDR_ROUTE: prdata = {12'd0, pend.out1_sel, pend.out0_sel, pend.gamma_sel,
                                  pend.wb_sel, pend.raw_sel};
            ADDR_BLACK: prdata = pend.black;
            ADDR_GAIN:  prdata = {8'd0, pend.wb_gain_b, pend.wb_gain_g, pend.wb_gain_r};
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= CFG_RESET;
        end else if (access && pwrite) begin
            case (paddr)
                ADDR_ROUTE: begin
                    pend.raw_sel   <= stage_id_t'(pwdata[3:0]);
                    pend.wb_sel    <= stage_id_t'(pwdata[7:4]);
                    pend.gamma_sel <= stage_id_t'(pwdata[11:8]);
                    pend.out0_sel  <= stage_id_t'(pwdata[15:12]);
                    pend.out1_sel  <= stage_id_t'(pwdata[19:16]);
                end
                ADDR_BLACK: pend.black <= pwdata;
                ADDR_GAIN: begin
                    pend.wb_gain_r <= pwdata[7:0];
                    pend.wb_gain_g <= pwdata[15:8];
                    pend.wb_gain_b <= pwdata[23:16];
                end
                default: ;
            endcase
        end
    end

    // frame end arms, then wait for the pipeline to empty
    assign commit = armed && (idle_cnt == CW'(DRAIN_CYCLES));

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            idle_cnt <= '0;
        end else begin
            if (frame_end) begin
                armed <= 1'b1;
            end else if (commit) begin
                armed <= 1'b0;
            end
            // any pixel restarts the idle count
            if (!armed || pix_en || commit) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= CFG_RESET;
        end else if (commit) begin
            cfg <= pend;
        end
    end

endmodule

`default_nettype wire

/* src/frame_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_counter #(
    parameter int IMG_WIDTH  = 1936,
    parameter int IMG_HEIGHT = 1088
) (
    input  logic                  mux_clk,
    input  logic                  rst_n,
    input  logic                  pix_en,
    output isp_pkg::bayer_phase_t phase,
    output logic                  frame_end
);

    localparam int HW = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam int VW = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          last_col;
    logic          last_row;

    assign last_col = (h_cnt == HW'(IMG_WIDTH - 1));
    assign last_row = (v_cnt == VW'(IMG_HEIGHT - 1));

    // only enabled pixels move the raster position
    always_ff @(posedge mux_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_en) begin
            if (last_col) begin
                h_cnt <= '0;
                v_cnt <= last_row ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // phase of the pixel presented this cycle, before the counts move
    assign phase     = {v_cnt[0], h_cnt[0]};
    assign frame_end = pix_en && last_col && last_row;

endmodule

`default_nettype wire

/* src/isp_pkg.sv */
`default_nettype none

package isp_pkg;

    // one raw sample, upper 8 bits of the 12-bit field
    typedef logic [7:0] pix_raw_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pix_rgb_t;

    typedef struct packed {
        logic     en;
        pix_raw_t pix;
    } raw_beat_t;

    typedef struct packed {
        logic     en;
        pix_rgb_t pix;
    } rgb_beat_t;

    // gaps in the numbering belong to stages not built here
    typedef enum logic [3:0] {
        SRC      = 4'd0,
        BLC      = 4'd2,
        DEMOSAIC = 4'd3,
        WB       = 4'd4,
        GAMMA    = 4'd6
    } stage_id_t;

    // {row parity, column parity}
    typedef logic [1:0] bayer_phase_t;

    typedef struct packed {
        stage_id_t       raw_sel;
        stage_id_t       wb_sel;
        stage_id_t       gamma_sel;
        stage_id_t       out0_sel;
        stage_id_t       out1_sel;
        logic [3:0][7:0] black;
        // 64 is unity gain
        logic [7:0]      wb_gain_r;
        logic [7:0]      wb_gain_g;
        logic [7:0]      wb_gain_b;
    } isp_cfg_t;

    localparam isp_cfg_t CFG_RESET = '{raw_sel: SRC, wb_sel: DEMOSAIC, gamma_sel: WB,
        out0_sel: GAMMA, out1_sel: DEMOSAIC, black: '0,
        wb_gain_r: 8'd64, wb_gain_g: 8'd64, wb_gain_b: 8'd64};

    localparam int unsigned DRAIN_CYCLES = 8;

    localparam logic [7:0] ADDR_ROUTE = 8'h00;
    localparam logic [7:0] ADDR_BLACK = 8'h04;
    localparam logic [7:0] ADDR_GAIN  = 8'h08;

endpackage

`default_nettype wire
